// File: design/alu_pipe.sv
// Two-stage integer ALU
`default_nettype none
`timescale 1ns/10ps

module alu_pipe #(
    parameter int DATA_WIDTH = 32,
    parameter int ROB_DEPTH  = 8,
    localparam int TAG_W     = $clog2(ROB_DEPTH)
) (
    input  wire logic                  clk,
    input  wire logic                  n_rst,
    input  wire logic                  i_flush,
    input  wire logic                  i_issue_valid,
    input  wire ooo_pkg::op_e          i_issue_op,
    input  wire logic [TAG_W-1:0]      i_issue_tag,
    input  wire logic [DATA_WIDTH-1:0] i_issue_a,
    input  wire logic [DATA_WIDTH-1:0] i_issue_b,
    output logic                       o_cmpl_valid,
    output logic [TAG_W-1:0]           o_cmpl_tag,
    output logic [DATA_WIDTH-1:0]      o_cmpl_data
);

    logic                  s1_valid;
    ooo_pkg::op_e          s1_op;
    logic [TAG_W-1:0]      s1_tag;
    logic [DATA_WIDTH-1:0] s1_a;
    logic [DATA_WIDTH-1:0] s1_b;
    logic [DATA_WIDTH-1:0] s1_result;

    // Stage one computes from the captured operands
    always_comb begin
        case (s1_op)
            ooo_pkg::OP_SUB: s1_result = s1_a - s1_b;
            ooo_pkg::OP_AND: s1_result = s1_a & s1_b;
            ooo_pkg::OP_OR:  s1_result = s1_a | s1_b;
            ooo_pkg::OP_XOR: s1_result = s1_a ^ s1_b;
            // ADD and ADDI share the adder, b already holds the immediate
            default:         s1_result = s1_a + s1_b;
        endcase
    end

    // Valid bits drop on flush so nothing older reaches the ROB
    always_ff @(posedge clk) begin
        if (!n_rst || i_flush) begin
            s1_valid     <= 1'b0;
            o_cmpl_valid <= 1'b0;
        end else begin
            s1_valid     <= i_issue_valid;
            o_cmpl_valid <= s1_valid;
        end
    end

    always_ff @(posedge clk) begin
        s1_op       <= i_issue_op;
        s1_tag      <= i_issue_tag;
        s1_a        <= i_issue_a;
        s1_b        <= i_issue_b;
        o_cmpl_tag  <= s1_tag;
        o_cmpl_data <= s1_result;
    end

endmodule

`default_nettype wire

// File: design/issue_station.sv
// Single-entry issue station
`default_nettype none
`timescale 1ns/10ps

module issue_station #(
    parameter int DATA_WIDTH = 32,
    parameter int ROB_DEPTH  = 8,
    localparam int TAG_W     = $clog2(ROB_DEPTH)
) (
    input  wire logic                  clk,
    input  wire logic                  n_rst,
    input  wire logic                  i_flush,
    input  wire logic                  i_accept,
    input  wire ooo_pkg::op_e          i_op,
    input  wire logic [DATA_WIDTH-1:0] i_imm,
    input  wire logic                  i_lookup_rdy0,
    input  wire logic [TAG_W-1:0]      i_lookup_tag0,
    input  wire logic [DATA_WIDTH-1:0] i_lookup_data0,
    input  wire logic                  i_lookup_rdy1,
    input  wire logic [TAG_W-1:0]      i_lookup_tag1,
    input  wire logic [DATA_WIDTH-1:0] i_lookup_data1,
    output logic [TAG_W-1:0]           o_read_tag0,
    input  wire logic                  i_read_done0,
    input  wire logic [DATA_WIDTH-1:0] i_read_data0,
    output logic [TAG_W-1:0]           o_read_tag1,
    input  wire logic                  i_read_done1,
    input  wire logic [DATA_WIDTH-1:0] i_read_data1,
    input  wire logic                  i_cmpl_valid,
    input  wire logic [TAG_W-1:0]      i_cmpl_tag,
    input  wire logic [DATA_WIDTH-1:0] i_cmpl_data,
    input  wire logic [TAG_W-1:0]      i_dest_tag,
    output logic                       o_empty,
    output logic                       o_issue_valid,
    output ooo_pkg::op_e               o_issue_op,
    output logic [TAG_W-1:0]           o_issue_tag,
    output logic [DATA_WIDTH-1:0]      o_issue_a,
    output logic [DATA_WIDTH-1:0]      o_issue_b
);

    // RESOLVE is the cycle after accept when the map lookup is visible
    typedef enum logic [1:0] {
        EMPTY,
        RESOLVE,
        WAIT
    } state_e;

    state_e                state_q;
    ooo_pkg::op_e          op_q;
    logic [TAG_W-1:0]      dest_q;
    logic                  res0_q;
    logic                  res1_q;
    logic [TAG_W-1:0]      tag0_q;
    logic [TAG_W-1:0]      tag1_q;
    logic [DATA_WIDTH-1:0] val0_q;
    logic [DATA_WIDTH-1:0] val1_q;
    logic                  fresh;
    logic                  avail0;
    logic                  avail1;
    logic [DATA_WIDTH-1:0] val0;
    logic [DATA_WIDTH-1:0] val1;

    // Operand priority: held value, then map, then finished ROB entry,
    // and last the completion bus in the same cycle
    function automatic logic [DATA_WIDTH:0] pick(
        input logic                  is_fresh,
        input logic                  held,
        input logic [DATA_WIDTH-1:0] held_val,
        input logic                  map_rdy,
        input logic [DATA_WIDTH-1:0] map_data,
        input logic                  rob_done,
        input logic [DATA_WIDTH-1:0] rob_data,
        input logic                  snoop,
        input logic [DATA_WIDTH-1:0] bus_data
    );
        if (held) return {1'b1, held_val};
        if (is_fresh && map_rdy) return {1'b1, map_data};
        if (is_fresh && rob_done) return {1'b1, rob_data};
        return {snoop, bus_data};
    endfunction

    assign fresh = state_q == RESOLVE;

    // Source tags come straight from the map on the first cycle
    assign o_read_tag0 = fresh ? i_lookup_tag0 : tag0_q;
    assign o_read_tag1 = fresh ? i_lookup_tag1 : tag1_q;

    assign {avail0, val0} = pick(fresh, res0_q, val0_q, i_lookup_rdy0, i_lookup_data0,
                                 i_read_done0, i_read_data0,
                                 i_cmpl_valid && i_cmpl_tag == o_read_tag0, i_cmpl_data);
    assign {avail1, val1} = pick(fresh, res1_q, val1_q, i_lookup_rdy1, i_lookup_data1,
                                 i_read_done1, i_read_data1,
                                 i_cmpl_valid && i_cmpl_tag == o_read_tag1, i_cmpl_data);

    // Issue goes out in the same cycle the last operand turns up
    assign o_empty       = state_q == EMPTY;
    assign o_issue_valid = !o_empty && avail0 && avail1;
    assign o_issue_op    = op_q;
    assign o_issue_tag   = dest_q;
    assign o_issue_a     = val0;
    assign o_issue_b     = val1;

    always_ff @(posedge clk) begin
        if (!n_rst || i_flush) begin
            state_q <= EMPTY;
            res0_q  <= 1'b0;
            res1_q  <= 1'b0;
        end else if (o_empty) begin
            if (i_accept) begin
                state_q <= RESOLVE;
                res0_q  <= 1'b0;
                // The immediate is source 1 of an ADDI and is known now
                res1_q  <= i_op == ooo_pkg::OP_ADDI;
            end
        end else if (o_issue_valid) begin
            state_q <= EMPTY;
        end else begin
            state_q <= WAIT;
            res0_q  <= avail0;
            res1_q  <= avail1;
        end
    end

    // Payload of the held instruction
    always_ff @(posedge clk) begin
        if (o_empty && i_accept) begin
            op_q   <= i_op;
            dest_q <= i_dest_tag;
            val1_q <= i_imm;
        end else if (!o_empty) begin
            tag0_q <= o_read_tag0;
            tag1_q <= o_read_tag1;
            val0_q <= val0;
            val1_q <= val1;
        end
    end

endmodule

`default_nettype wire

// File: design/ooo_core.sv
// Out-of-order rename and retire core
`default_nettype none
`timescale 1ns/10ps

module ooo_core #(
    parameter int DATA_WIDTH = 32,
    parameter int REG_COUNT  = 32,
    parameter int ROB_DEPTH  = 8,
    localparam int IDX_W     = $clog2(REG_COUNT),
    localparam int TAG_W     = $clog2(ROB_DEPTH)
) (
    input  wire logic                  clk,
    input  wire logic                  n_rst,
    input  wire logic                  i_flush,
    input  wire logic                  i_ins_valid,
    input  wire ooo_pkg::op_e          i_ins_op,
    input  wire logic [IDX_W-1:0]      i_ins_rdest,
    input  wire logic [IDX_W-1:0]      i_ins_rsrc0,
    input  wire logic [IDX_W-1:0]      i_ins_rsrc1,
    input  wire logic [DATA_WIDTH-1:0] i_ins_imm,
    output logic                       o_ins_ready,
    output logic                       o_retire_valid,
    output logic [IDX_W-1:0]           o_retire_rdest,
    output logic [DATA_WIDTH-1:0]      o_retire_data
);

    logic                  transfer;
    logic                  st_empty;
    logic                  rob_full;
    logic [TAG_W-1:0]      alloc_tag;
    logic [TAG_W-1:0]      retire_tag;
    logic                  lk_rdy0;
    logic                  lk_rdy1;
    logic [TAG_W-1:0]      lk_tag0;
    logic [TAG_W-1:0]      lk_tag1;
    logic [DATA_WIDTH-1:0] lk_data0;
    logic [DATA_WIDTH-1:0] lk_data1;
    logic [TAG_W-1:0]      rd_tag0;
    logic [TAG_W-1:0]      rd_tag1;
    logic                  rd_done0;
    logic                  rd_done1;
    logic [DATA_WIDTH-1:0] rd_data0;
    logic [DATA_WIDTH-1:0] rd_data1;
    logic                  iss_valid;
    ooo_pkg::op_e          iss_op;
    logic [TAG_W-1:0]      iss_tag;
    logic [DATA_WIDTH-1:0] iss_a;
    logic [DATA_WIDTH-1:0] iss_b;
    logic                  cmpl_valid;
    logic [TAG_W-1:0]      cmpl_tag;
    logic [DATA_WIDTH-1:0] cmpl_data;

    // One instruction in the station at a time and a free ROB slot
    assign o_ins_ready = st_empty && !rob_full && !i_flush;
    assign transfer    = i_ins_valid && o_ins_ready;

    register_map #(
        .DATA_WIDTH(DATA_WIDTH), .REG_COUNT(REG_COUNT), .ROB_DEPTH(ROB_DEPTH)
    ) u_map (
        .clk(clk), .n_rst(n_rst), .i_flush(i_flush),
        .i_retire_en(o_retire_valid), .i_retire_rdest(o_retire_rdest),
        .i_retire_tag(retire_tag), .i_retire_data(o_retire_data),
        .i_rename_en(transfer), .i_rename_rdest(i_ins_rdest), .i_rename_tag(alloc_tag),
        .i_lookup_valid(transfer), .i_lookup_rsrc0(i_ins_rsrc0), .i_lookup_rsrc1(i_ins_rsrc1),
        .o_lookup_rdy0(lk_rdy0), .o_lookup_tag0(lk_tag0), .o_lookup_data0(lk_data0),
        .o_lookup_rdy1(lk_rdy1), .o_lookup_tag1(lk_tag1), .o_lookup_data1(lk_data1)
    );

    reorder_buffer #(
        .DATA_WIDTH(DATA_WIDTH), .REG_COUNT(REG_COUNT), .ROB_DEPTH(ROB_DEPTH)
    ) u_rob (
        .clk(clk), .n_rst(n_rst), .i_flush(i_flush),
        .i_alloc_en(transfer), .i_alloc_rdest(i_ins_rdest),
        .o_alloc_tag(alloc_tag), .o_full(rob_full),
        .i_cmpl_valid(cmpl_valid), .i_cmpl_tag(cmpl_tag), .i_cmpl_data(cmpl_data),
        .i_read_tag0(rd_tag0), .o_read_done0(rd_done0), .o_read_data0(rd_data0),
        .i_read_tag1(rd_tag1), .o_read_done1(rd_done1), .o_read_data1(rd_data1),
        .o_retire_valid(o_retire_valid), .o_retire_rdest(o_retire_rdest),
        .o_retire_tag(retire_tag), .o_retire_data(o_retire_data)
    );

    issue_station #(
        .DATA_WIDTH(DATA_WIDTH), .ROB_DEPTH(ROB_DEPTH)
    ) u_station (
        .clk(clk), .n_rst(n_rst), .i_flush(i_flush),
        .i_accept(transfer), .i_op(i_ins_op), .i_imm(i_ins_imm),
        .i_lookup_rdy0(lk_rdy0), .i_lookup_tag0(lk_tag0), .i_lookup_data0(lk_data0),
        .i_lookup_rdy1(lk_rdy1), .i_lookup_tag1(lk_tag1), .i_lookup_data1(lk_data1),
        .o_read_tag0(rd_tag0), .i_read_done0(rd_done0), .i_read_data0(rd_data0),
        .o_read_tag1(rd_tag1), .i_read_done1(rd_done1), .i_read_data1(rd_data1),
        .i_cmpl_valid(cmpl_valid), .i_cmpl_tag(cmpl_tag), .i_cmpl_data(cmpl_data),
        .i_dest_tag(alloc_tag), .o_empty(st_empty),
        .o_issue_valid(iss_valid), .o_issue_op(iss_op), .o_issue_tag(iss_tag),
        .o_issue_a(iss_a), .o_issue_b(iss_b)
    );

    alu_pipe #(
        .DATA_WIDTH(DATA_WIDTH), .ROB_DEPTH(ROB_DEPTH)
    ) u_alu (
        .clk(clk), .n_rst(n_rst), .i_flush(i_flush),
        .i_issue_valid(iss_valid), .i_issue_op(iss_op), .i_issue_tag(iss_tag),
        .i_issue_a(iss_a), .i_issue_b(iss_b),
        .o_cmpl_valid(cmpl_valid), .o_cmpl_tag(cmpl_tag), .o_cmpl_data(cmpl_data)
    );

endmodule

`default_nettype wire

// File: design/ooo_pkg.sv
// Core shared types
`default_nettype none

package ooo_pkg;

    // Integer operations, all register-register except OP_ADDI
    // OP_ADDI adds the immediate to source 0 and ignores source 1
    typedef enum logic [2:0] {
        OP_ADD  = 3'd0,
        OP_SUB  = 3'd1,
        OP_AND  = 3'd2,
        OP_OR   = 3'd3,
        OP_XOR  = 3'd4,
        OP_ADDI = 3'd5
    } op_e;

endpackage

`default_nettype wire

// File: design/register_map.sv
// Register map with rename tags
`default_nettype none
`timescale 1ns/10ps

module register_map #(
    parameter int DATA_WIDTH = 32,
    parameter int REG_COUNT  = 32,
    parameter int ROB_DEPTH  = 8,
    localparam int IDX_W     = $clog2(REG_COUNT),
    localparam int TAG_W     = $clog2(ROB_DEPTH)
) (
    input  wire logic                  clk,
    input  wire logic                  n_rst,
    input  wire logic                  i_flush,
    input  wire logic                  i_retire_en,
    input  wire logic [IDX_W-1:0]      i_retire_rdest,
    input  wire logic [TAG_W-1:0]      i_retire_tag,
    input  wire logic [DATA_WIDTH-1:0] i_retire_data,
    input  wire logic                  i_rename_en,
    input  wire logic [IDX_W-1:0]      i_rename_rdest,
    input  wire logic [TAG_W-1:0]      i_rename_tag,
    input  wire logic                  i_lookup_valid,
    input  wire logic [IDX_W-1:0]      i_lookup_rsrc0,
    input  wire logic [IDX_W-1:0]      i_lookup_rsrc1,
    output logic                       o_lookup_rdy0,
    output logic [TAG_W-1:0]           o_lookup_tag0,
    output logic [DATA_WIDTH-1:0]      o_lookup_data0,
    output logic                       o_lookup_rdy1,
    output logic [TAG_W-1:0]           o_lookup_tag1,
    output logic [DATA_WIDTH-1:0]      o_lookup_data1
);

    // Per register state: committed value, producing ROB tag and ready bit
    // A register is ready when no instruction in flight will write it
    logic [DATA_WIDTH-1:0] data_q [REG_COUNT];
    logic [TAG_W-1:0]      tag_q  [REG_COUNT];
    logic [REG_COUNT-1:0]  rdy_q;
    logic [REG_COUNT-1:0]  rdy_next;
    logic [REG_COUNT-1:0]  retire_sel;
    logic [REG_COUNT-1:0]  rename_sel;
    logic                  bypass0;
    logic                  bypass1;

    // One-hot write selects, r0 is never selected so it stays zero and ready
    always_comb begin
        retire_sel = '0;
        rename_sel = '0;
        if (i_retire_en && i_retire_rdest != '0) begin
            retire_sel[i_retire_rdest] = 1'b1;
        end
        if (i_rename_en && i_rename_rdest != '0) begin
            rename_sel[i_rename_rdest] = 1'b1;
        end
    end

    // A new rename wins over a retire of the same register in one cycle
    // A retire only marks ready when it is still the newest producer
    always_comb begin
        for (int i = 0; i < REG_COUNT; i++) begin
            if (rename_sel[i]) begin
                rdy_next[i] = 1'b0;
            end else if (retire_sel[i]) begin
                rdy_next[i] = rdy_q[i] | (tag_q[i] == i_retire_tag);
            end else begin
                rdy_next[i] = rdy_q[i];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!n_rst) begin
            for (int i = 0; i < REG_COUNT; i++) begin
                data_q[i] <= '0;
                tag_q[i]  <= '0;
            end
            rdy_q <= '1;
        end else begin
            for (int i = 1; i < REG_COUNT; i++) begin
                if (rename_sel[i]) begin
                    tag_q[i] <= i_rename_tag;
                end
                if (retire_sel[i]) begin
                    data_q[i] <= i_retire_data;
                end
            end
            // Flush drops every in-flight producer, so the stored values are current
            rdy_q <= rdy_next | {REG_COUNT{i_flush}};
        end
    end

    // The lookup sees the state before this edge, so a retiring producer
    // must be forwarded or the source would wait for a value already gone
    assign bypass0 = i_retire_en && !rdy_q[i_lookup_rsrc0]
                     && i_retire_rdest == i_lookup_rsrc0
                     && tag_q[i_lookup_rsrc0] == i_retire_tag;
    assign bypass1 = i_retire_en && !rdy_q[i_lookup_rsrc1]
                     && i_retire_rdest == i_lookup_rsrc1
                     && tag_q[i_lookup_rsrc1] == i_retire_tag;

    // Lookup results are held until the next dispatch
    always_ff @(posedge clk) begin
        if (i_lookup_valid) begin
            o_lookup_rdy0  <= rdy_q[i_lookup_rsrc0] | bypass0;
            o_lookup_tag0  <= tag_q[i_lookup_rsrc0];
            o_lookup_data0 <= bypass0 ? i_retire_data : data_q[i_lookup_rsrc0];
            o_lookup_rdy1  <= rdy_q[i_lookup_rsrc1] | bypass1;
            o_lookup_tag1  <= tag_q[i_lookup_rsrc1];
            o_lookup_data1 <= bypass1 ? i_retire_data : data_q[i_lookup_rsrc1];
        end
    end

    // Dispatch must be held off while a flush restores the map
    a_no_dispatch_in_flush: assert property (@(posedge clk) disable iff (!n_rst)
        i_flush |-> !i_rename_en && !i_lookup_valid);

endmodule

`default_nettype wire

// File: design/reorder_buffer.sv
// In-order reorder buffer
`default_nettype none
`timescale 1ns/10ps

module reorder_buffer #(
    parameter int DATA_WIDTH = 32,
    parameter int REG_COUNT  = 32,
    parameter int ROB_DEPTH  = 8,
    localparam int IDX_W     = $clog2(REG_COUNT),
    localparam int TAG_W     = $clog2(ROB_DEPTH)
) (
    input  wire logic                  clk,
    input  wire logic                  n_rst,
    input  wire logic                  i_flush,
    input  wire logic                  i_alloc_en,
    input  wire logic [IDX_W-1:0]      i_alloc_rdest,
    output logic [TAG_W-1:0]           o_alloc_tag,
    output logic                       o_full,
    input  wire logic                  i_cmpl_valid,
    input  wire logic [TAG_W-1:0]      i_cmpl_tag,
    input  wire logic [DATA_WIDTH-1:0] i_cmpl_data,
    input  wire logic [TAG_W-1:0]      i_read_tag0,
    output logic                       o_read_done0,
    output logic [DATA_WIDTH-1:0]      o_read_data0,
    input  wire logic [TAG_W-1:0]      i_read_tag1,
    output logic                       o_read_done1,
    output logic [DATA_WIDTH-1:0]      o_read_data1,
    output logic                       o_retire_valid,
    output logic [IDX_W-1:0]           o_retire_rdest,
    output logic [TAG_W-1:0]           o_retire_tag,
    output logic [DATA_WIDTH-1:0]      o_retire_data
);

    // Count needs one extra bit to tell full from empty
    localparam int CNT_W = TAG_W + 1;

    logic [ROB_DEPTH-1:0]  valid_q;
    logic [ROB_DEPTH-1:0]  done_q;
    logic [IDX_W-1:0]      rdest_q [ROB_DEPTH];
    logic [DATA_WIDTH-1:0] data_q  [ROB_DEPTH];
    logic [TAG_W-1:0]      head_q;
    logic [TAG_W-1:0]      tail_q;
    logic [CNT_W-1:0]      count_q;
    logic                  retire;

    // The tail slot is the tag handed to the next dispatched instruction
    assign o_alloc_tag = tail_q;
    assign o_full      = count_q == CNT_W'(ROB_DEPTH);

    // The head leaves as soon as its result is in, one entry per cycle
    assign retire         = valid_q[head_q] & done_q[head_q];
    assign o_retire_valid = retire;
    assign o_retire_rdest = rdest_q[head_q];
    assign o_retire_tag   = head_q;
    assign o_retire_data  = data_q[head_q];

    // Operand read ports for sources whose producer finished but has not retired
    assign o_read_done0 = valid_q[i_read_tag0] & done_q[i_read_tag0];
    assign o_read_data0 = data_q[i_read_tag0];
    assign o_read_done1 = valid_q[i_read_tag1] & done_q[i_read_tag1];
    assign o_read_data1 = data_q[i_read_tag1];

    always_ff @(posedge clk) begin
        if (!n_rst) begin
            valid_q <= '0;
            done_q  <= '0;
            head_q  <= '0;
            tail_q  <= '0;
            count_q <= '0;
        end else if (i_flush) begin
            // The head may still retire this cycle, everything else is dropped
            valid_q <= '0;
            head_q  <= '0;
            tail_q  <= '0;
            count_q <= '0;
        end else begin
            if (i_cmpl_valid) begin
                done_q[i_cmpl_tag] <= 1'b1;
            end
            if (retire) begin
                valid_q[head_q] <= 1'b0;
                head_q          <= head_q + 1'b1;
            end
            if (i_alloc_en) begin
                valid_q[tail_q] <= 1'b1;
                done_q[tail_q]  <= 1'b0;
                tail_q          <= tail_q + 1'b1;
            end
            if (i_alloc_en && !retire) begin
                count_q <= count_q + 1'b1;
            end else if (!i_alloc_en && retire) begin
                count_q <= count_q - 1'b1;
            end
        end
    end

    // Payload is qualified by the valid and done bits
    always_ff @(posedge clk) begin
        if (i_alloc_en) begin
            rdest_q[tail_q] <= i_alloc_rdest;
        end
        if (i_cmpl_valid) begin
            data_q[i_cmpl_tag] <= i_cmpl_data;
        end
    end

    a_no_alloc_full: assert property (@(posedge clk) disable iff (!n_rst)
        i_alloc_en |-> !o_full);

    // A result must belong to a live entry and arrive only once
    a_cmpl_live: assert property (@(posedge clk) disable iff (!n_rst)
        i_cmpl_valid |-> valid_q[i_cmpl_tag] && !done_q[i_cmpl_tag]);

endmodule

`default_nettype wire

// File: ooo_core.f
design/ooo_pkg.sv
design/register_map.sv
design/reorder_buffer.sv
design/issue_station.sv
design/alu_pipe.sv
design/ooo_core.sv
tb/ooo_core_tb.sv

// File: run.sh
#!/usr/bin/env bash
# Build and run the ooo_core testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
    --top-module ooo_core_tb \
    -f ooo_core.f \
    -o Vooo_core_tb

./obj_dir/Vooo_core_tb

// File: tb/ooo_core_tb.sv
// Rename and retire core testbench
`default_nettype none
`timescale 1ns/10ps

module ooo_core_tb;

    localparam int DATA_WIDTH  = 32;
    localparam int REG_COUNT   = 32;
    localparam int ROB_DEPTH   = 8;
    localparam int IDX_W       = $clog2(REG_COUNT);
    // About 300 instructions at up to 10 cycles each with margin
    localparam int CYCLE_LIMIT = 4000;

    // One dispatched instruction as the model remembers it
    typedef struct packed {
        ooo_pkg::op_e          op;
        logic [IDX_W-1:0]      rd;
        logic [IDX_W-1:0]      rs0;
        logic [IDX_W-1:0]      rs1;
        logic [DATA_WIDTH-1:0] imm;
    } ins_t;

    logic                  clk;
    logic                  n_rst;
    logic                  i_flush;
    logic                  i_ins_valid;
    ooo_pkg::op_e          i_ins_op;
    logic [IDX_W-1:0]      i_ins_rdest;
    logic [IDX_W-1:0]      i_ins_rsrc0;
    logic [IDX_W-1:0]      i_ins_rsrc1;
    logic [DATA_WIDTH-1:0] i_ins_imm;
    logic                  o_ins_ready;
    logic                  o_retire_valid;
    logic [IDX_W-1:0]      o_retire_rdest;
    logic [DATA_WIDTH-1:0] o_retire_data;

    // Reference model with a program-order queue and architectural registers
    ins_t                  model_q [$];
    logic [DATA_WIDTH-1:0] arch [REG_COUNT];
    logic                  exp_valid;
    logic [IDX_W-1:0]      exp_rdest;
    logic [DATA_WIDTH-1:0] exp_data;
    int                    transferred;
    int                    retired;
    int                    dropped;
    int                    cycle_count = 0;
    string                 test_name = "reset";

    ooo_core #(
        .DATA_WIDTH(DATA_WIDTH), .REG_COUNT(REG_COUNT), .ROB_DEPTH(ROB_DEPTH)
    ) i_dut (
        .clk(clk), .n_rst(n_rst), .i_flush(i_flush),
        .i_ins_valid(i_ins_valid), .i_ins_op(i_ins_op), .i_ins_rdest(i_ins_rdest),
        .i_ins_rsrc0(i_ins_rsrc0), .i_ins_rsrc1(i_ins_rsrc1), .i_ins_imm(i_ins_imm),
        .o_ins_ready(o_ins_ready), .o_retire_valid(o_retire_valid),
        .o_retire_rdest(o_retire_rdest), .o_retire_data(o_retire_data)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    task automatic stop_on_error(input string why);
        $display("%s", why);
        $display("Test failed");
        $fatal(1, "Stopping at the first error");
    endtask

    // Result by the op rule with r0 reading as zero from the model array
    function automatic logic [DATA_WIDTH-1:0] expected_result(input ins_t ins);
        logic [DATA_WIDTH-1:0] a;
        logic [DATA_WIDTH-1:0] b;
        a = arch[ins.rs0];
        b = arch[ins.rs1];
        case (ins.op)
            ooo_pkg::OP_SUB:  return a - b;
            ooo_pkg::OP_AND:  return a & b;
            ooo_pkg::OP_OR:   return a | b;
            ooo_pkg::OP_XOR:  return a ^ b;
            ooo_pkg::OP_ADDI: return a + ins.imm;
            default:          return a + b;
        endcase
    endfunction

    function automatic logic [IDX_W-1:0] rand_reg(input int lo);
        return IDX_W'($urandom_range(REG_COUNT - 1, lo));
    endfunction

    function automatic ooo_pkg::op_e rand_op();
        return ooo_pkg::op_e'(3'($urandom_range(5, 0)));
    endfunction

    // Holds the payload until the core takes it and then idles for gap cycles
    task automatic send_ins(input ooo_pkg::op_e op, input logic [IDX_W-1:0] rd,
                            input logic [IDX_W-1:0] rs0, input logic [IDX_W-1:0] rs1,
                            input logic [DATA_WIDTH-1:0] imm, input int gap);
        i_ins_valid <= 1'b1;
        i_ins_op    <= op;
        i_ins_rdest <= rd;
        i_ins_rsrc0 <= rs0;
        i_ins_rsrc1 <= rs1;
        i_ins_imm   <= imm;
        @(posedge clk);
        while (!o_ins_ready) begin
            @(posedge clk);
        end
        i_ins_valid <= 1'b0;
        repeat (gap) @(posedge clk);
    endtask

    task automatic flush_core();
        i_flush <= 1'b1;
        @(posedge clk);
        i_flush <= 1'b0;
    endtask

    // Model follows the core edge by edge and sets up the next expected retirement
    always @(posedge clk) begin
        ins_t head;
        if (!n_rst) begin
            model_q.delete();
            for (int i = 0; i < REG_COUNT; i++) begin
                arch[i] = '0;
            end
            transferred = 0;
            retired     = 0;
            dropped     = 0;
            exp_valid   <= 1'b0;
            exp_rdest   <= '0;
            exp_data    <= '0;
        end else begin
            // Every retirement the core reports is counted
            if (o_retire_valid) begin
                retired++;
                if (model_q.size() != 0) begin
                    head = model_q.pop_front();
                    if (head.rd != '0) begin
                        arch[head.rd] = expected_result(head);
                    end
                end
            end
            // A retirement in the flush cycle still counts while the rest is dropped
            if (i_flush) begin
                dropped += model_q.size();
                model_q.delete();
            end
            if (i_ins_valid && o_ins_ready) begin
                model_q.push_back({i_ins_op, i_ins_rdest, i_ins_rsrc0, i_ins_rsrc1, i_ins_imm});
                transferred++;
            end
            exp_valid <= model_q.size() != 0;
            if (model_q.size() != 0) begin
                exp_rdest <= model_q[0].rd;
                exp_data  <= expected_result(model_q[0]);
            end
        end
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= CYCLE_LIMIT) begin
            stop_on_error("Timeout, the run did not drain within the cycle limit");
        end
    end

    a_reset_idle: assert property (@(posedge clk) $rose(n_rst) |-> !o_retire_valid && o_ins_ready)
        else stop_on_error("Core was not idle and ready right after reset");

    // A retirement with nothing outstanding means a lost flush or a duplicate
    a_retire_owned: assert property (@(posedge clk) disable iff (!n_rst)
        o_retire_valid |-> exp_valid)
        else stop_on_error("An instruction retired that the model never saw or had dropped");

    a_flush_drops: assert property (@(posedge clk) disable iff (!n_rst)
        i_flush |=> !o_retire_valid)
        else stop_on_error("An instruction retired in the cycle after a flush");

    a_retire_rdest: assert property (@(posedge clk) disable iff (!n_rst)
        o_retire_valid && exp_valid |-> o_retire_rdest == exp_rdest)
        else stop_on_error($sformatf("MISMATCH %s retire rdest: expected %0d, actual %0d",
                                     test_name, $sampled(exp_rdest), $sampled(o_retire_rdest)));

    a_retire_data: assert property (@(posedge clk) disable iff (!n_rst)
        o_retire_valid && exp_valid |-> o_retire_data == exp_data)
        else stop_on_error($sformatf("MISMATCH %s retire data: expected %h, actual %h",
                                     test_name, $sampled(exp_data), $sampled(o_retire_data)));

    initial begin
        logic [IDX_W-1:0] rd;
        logic [IDX_W-1:0] prev_rd;
        logic [IDX_W-1:0] src1;
        int               flush_at;
        void'($urandom(32'h8901_ec38));
        n_rst       <= 1'b0;
        i_flush     <= 1'b0;
        i_ins_valid <= 1'b0;
        i_ins_op    <= ooo_pkg::OP_ADD;
        i_ins_rdest <= '0;
        i_ins_rsrc0 <= '0;
        i_ins_rsrc1 <= '0;
        i_ins_imm   <= '0;
        repeat (8) @(posedge clk);
        n_rst <= 1'b1;

        // Random sources make only the odd pair of instructions depend on each other
        test_name = "random_ops";
        for (int i = 0; i < 100; i++) begin
            send_ins(rand_op(), rand_reg(1), rand_reg(0), rand_reg(0),
                     DATA_WIDTH'($urandom()), int'($urandom_range(2, 0)));
        end

        // Each instruction reads the last result and sometimes writes its own source
        // Gaps up to three cycles move the lookup across snoop, ROB read and retire bypass
        test_name = "dep_chain";
        prev_rd = rand_reg(1);
        for (int i = 0; i < 80; i++) begin
            rd   = ($urandom_range(3, 0) == 0) ? prev_rd : rand_reg(1);
            src1 = ($urandom_range(1, 0) == 0) ? prev_rd : rand_reg(0);
            send_ins(rand_op(), rd, prev_rd, src1, DATA_WIDTH'($urandom()),
                     int'($urandom_range(3, 0)));
            prev_rd = rd;
        end

        test_name = "r0_write";
        for (int i = 0; i < 12; i++) begin
            rd = (i % 2 == 0) ? '0 : rand_reg(1);
            send_ins(rand_op(), rd, '0, rand_reg(0), DATA_WIDTH'($urandom()), 0);
        end

        // The instruction just taken is still in flight when the flush lands
        test_name = "flush";
        for (int round = 0; round < 2; round++) begin
            flush_at = int'($urandom_range(25, 5));
            for (int i = 0; i < 30; i++) begin
                send_ins(rand_op(), rand_reg(1), rand_reg(0), rand_reg(0),
                         DATA_WIDTH'($urandom()), int'($urandom_range(1, 0)));
                if (i == flush_at) begin
                    flush_core();
                end
            end
        end

        test_name = "drain";
        do begin
            @(negedge clk);
        end while (model_q.size() != 0);
        repeat (10) @(negedge clk);
        if (retired == transferred - dropped) begin
            $display("Test completed successfully");
            $finish;
        end else begin
            stop_on_error($sformatf("MISMATCH %s retirements: expected %0d, actual %0d",
                                    test_name, transferred - dropped, retired));
        end
    end

endmodule

`default_nettype wire
